// File: vlog.f
common/ftdi_pkg.sv
hw/byte_fifo.sv
ftdi_fsm/ftdi_245fifo_fsm.sv
hw/ftdi_245fifo_top.sv
tb/tb_ftdi_chip_model.sv
tb/tb_ftdi_245fifo.sv

// File: tb/tb_ftdi_245fifo.sv
//------------------------------------------------
// directed testbench for the 245 FIFO controller, one task
// per behavior, results summed up at the end
//------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_ftdi_245fifo;

    import ftdi_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 5;
    localparam int LEN        = 40;
    localparam int BP_HOLD    = 200;
    // five streams of LEN bytes plus the send back-pressure fill
    localparam int TOTAL_BYTES = 5 * LEN + FIFO_DEPTH + 1;

    logic              ftdi_clk;
    logic              i_arst_n;
    logic              i_tx_tvalid;
    logic [DATA_W-1:0] i_tx_tdata;
    logic              o_tx_tready;
    logic              o_rx_tvalid;
    logic [DATA_W-1:0] o_rx_tdata;
    logic              i_rx_tready;
    logic              ftdi_rxf_n;
    logic              ftdi_txe_n;
    logic              ftdi_oe_n;
    logic              ftdi_rd_n;
    logic              ftdi_wr_n;
    logic [DATA_W-1:0] chip_to_fpga;
    logic [DATA_W-1:0] fpga_to_chip;
    logic              ftdi_data_oe;

    integer            seed;
    int                err_count;
    int                check_count;
    int                tx_accepted;
    logic [DATA_W-1:0] tx_expect[$];
    logic [DATA_W-1:0] rx_expect[$];
    logic [DATA_W-1:0] rx_got[$];

    ftdi_245fifo_top i_dut (
        .i_arst_n       (i_arst_n),
        .ftdi_clk       (ftdi_clk),
        .i_tx_tvalid    (i_tx_tvalid),
        .i_tx_tdata     (i_tx_tdata),
        .o_tx_tready    (o_tx_tready),
        .o_rx_tvalid    (o_rx_tvalid),
        .o_rx_tdata     (o_rx_tdata),
        .i_rx_tready    (i_rx_tready),
        .i_ftdi_rxf_n   (ftdi_rxf_n),
        .i_ftdi_txe_n   (ftdi_txe_n),
        .o_ftdi_oe_n    (ftdi_oe_n),
        .o_ftdi_rd_n    (ftdi_rd_n),
        .o_ftdi_wr_n    (ftdi_wr_n),
        .i_ftdi_data    (chip_to_fpga),
        .o_ftdi_data    (fpga_to_chip),
        .o_ftdi_data_oe (ftdi_data_oe)
    );

    tb_ftdi_chip_model #(
        .DRIVE_DLY (DRIVE_DLY)
    ) u_chip (
        .i_clk     (ftdi_clk),
        .i_oe_n    (ftdi_oe_n),
        .i_rd_n    (ftdi_rd_n),
        .i_wr_n    (ftdi_wr_n),
        .i_data    (fpga_to_chip),
        .i_data_oe (ftdi_data_oe),
        .o_rxf_n   (ftdi_rxf_n),
        .o_txe_n   (ftdi_txe_n),
        .o_data    (chip_to_fpga)
    );

    initial begin
        ftdi_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ftdi_clk = ~ftdi_clk;
    end

    // user receive side, a transfer is seen mid-cycle before its edge
    always @(negedge ftdi_clk) begin
        if (i_arst_n && o_rx_tvalid && i_rx_tready) begin
            rx_got.push_back(o_rx_tdata);
        end
    end

    //------------------------------------------------
    // helpers
    //------------------------------------------------
    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            err_count++;
            $display("[FAIL] %0d ns %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge ftdi_clk);
        #DRIVE_DLY;
    endtask

    // keeps valid and data steady until each byte is taken
    task automatic drive_tx(input int count, input int max_cycles);
        int   cycles;
        logic xfer;
        cycles      = 0;
        tx_accepted = 0;
        if (!i_tx_tvalid && count > 0) begin
            i_tx_tvalid = 1'b1;
            i_tx_tdata  = $random(seed);
        end
        while (tx_accepted < count && cycles < max_cycles) begin
            @(negedge ftdi_clk);
            xfer = i_tx_tvalid && o_tx_tready;
            @(posedge ftdi_clk);
            #DRIVE_DLY;
            cycles++;
            if (xfer) begin
                tx_expect.push_back(i_tx_tdata);
                tx_accepted++;
                if (tx_accepted < count) begin
                    i_tx_tdata = $random(seed);
                end else begin
                    i_tx_tvalid = 1'b0;
                end
            end
        end
    endtask

    task automatic offer_rx(input int count);
        logic [DATA_W-1:0] b;
        repeat (count) begin
            b = $random(seed);
            rx_expect.push_back(b);
            u_chip.offer_byte(b);
        end
    endtask

    task automatic wait_rx_count(input int n, input int max_cycles);
        int cycles;
        cycles = 0;
        while (rx_got.size() < n && cycles < max_cycles) begin
            @(posedge ftdi_clk);
            cycles++;
        end
        #DRIVE_DLY;
        if (rx_got.size() < n) begin
            err_count++;
            $display("timeout: expected %0d received bytes within %0d cycles, got %0d",
                     n, max_cycles, rx_got.size());
        end
    endtask

    task automatic wait_tx_count(input int n, input int max_cycles);
        int cycles;
        cycles = 0;
        while (u_chip.written_count() < n && cycles < max_cycles) begin
            @(posedge ftdi_clk);
            cycles++;
        end
        #DRIVE_DLY;
        if (u_chip.written_count() < n) begin
            err_count++;
            $display("timeout: expected %0d bytes written to the chip within %0d cycles, got %0d",
                     n, max_cycles, u_chip.written_count());
        end
    endtask

    task automatic compare_sent();
        logic [DATA_W-1:0] b;
        int                n;
        int                i;
        n = u_chip.written_count();
        check("written byte count", tx_expect.size(), n);
        for (i = 0; i < n; i++) begin
            u_chip.take_written(b);
            if (i < tx_expect.size()) begin
                check("o_ftdi_data", tx_expect[i], b);
            end
        end
        tx_expect.delete();
    endtask

    task automatic compare_received();
        int i;
        check("received byte count", rx_expect.size(), rx_got.size());
        for (i = 0; i < rx_got.size() && i < rx_expect.size(); i++) begin
            check("o_rx_tdata", rx_expect[i], rx_got[i]);
        end
        rx_expect.delete();
        rx_got.delete();
    endtask

    task automatic check_idle_outputs();
        check("o_ftdi_oe_n", 1, ftdi_oe_n);
        check("o_ftdi_rd_n", 1, ftdi_rd_n);
        check("o_ftdi_wr_n", 1, ftdi_wr_n);
        check("o_ftdi_data_oe", 0, ftdi_data_oe);
        check("o_rx_tvalid", 0, o_rx_tvalid);
        check("o_tx_tready", 1, o_tx_tready);
    endtask

    //------------------------------------------------
    // tests
    //------------------------------------------------
    task automatic test_reset_values();
        int errs;
        errs     = err_count;
        i_arst_n = 1'b0;
        repeat (3) @(posedge ftdi_clk);
        @(negedge ftdi_clk);
        check_idle_outputs();
        @(posedge ftdi_clk);
        #DRIVE_DLY;
        i_arst_n = 1'b1;
        @(posedge ftdi_clk);
        @(negedge ftdi_clk);
        check_idle_outputs();
        idle_cycles(1);
        report_test("reset values", errs);
    endtask

    task automatic test_send_order();
        int errs;
        errs = err_count;
        drive_tx(LEN, LEN * 20);
        check("accepted send bytes", LEN, tx_accepted);
        wait_tx_count(LEN, LEN * 20);
        compare_sent();
        report_test("send order", errs);
    endtask

    task automatic test_receive_order();
        int errs;
        errs = err_count;
        offer_rx(LEN);
        wait_rx_count(LEN, LEN * 20);
        compare_received();
        report_test("receive order", errs);
    endtask

    task automatic test_receive_backpressure();
        int errs;
        errs        = err_count;
        i_rx_tready = 1'b0;
        offer_rx(LEN);
        idle_cycles(BP_HOLD);
        @(negedge ftdi_clk);
        check("o_rx_tvalid", 1, o_rx_tvalid);
        // the chip keeps the rest, RD# must be released
        check("o_ftdi_rd_n", 1, ftdi_rd_n);
        idle_cycles(1);
        i_rx_tready = 1'b1;
        wait_rx_count(LEN, LEN * 20);
        compare_received();
        report_test("receive back-pressure", errs);
    endtask

    task automatic test_send_backpressure();
        int errs;
        errs = err_count;
        u_chip.hold_txe(1'b1);
        idle_cycles(2);
        drive_tx(LEN, LEN);
        @(negedge ftdi_clk);
        // the FIFO plus the FSM holding register
        check("accepted send bytes", FIFO_DEPTH + 1, tx_accepted);
        check("o_tx_tready", 0, o_tx_tready);
        check("written byte count", 0, u_chip.written_count());
        idle_cycles(1);
        u_chip.hold_txe(1'b0);
        drive_tx(1, LEN * 20);
        check("accepted send bytes", 1, tx_accepted);
        wait_tx_count(FIFO_DEPTH + 2, LEN * 20);
        compare_sent();
        report_test("send back-pressure", errs);
    endtask

    task automatic test_bus_direction();
        int errs;
        errs = err_count;
        offer_rx(LEN);
        drive_tx(LEN, LEN * 20);
        check("accepted send bytes", LEN, tx_accepted);
        wait_rx_count(LEN, LEN * 20);
        wait_tx_count(LEN, LEN * 20);
        check("bus direction errors", 0, u_chip.bus_error_count);
        compare_received();
        compare_sent();
        report_test("bus direction", errs);
    endtask

    initial begin
        seed        = 72573;
        err_count   = 0;
        check_count = 0;
        i_arst_n    = 1'b0;
        i_tx_tvalid = 1'b0;
        i_tx_tdata  = '0;
        i_rx_tready = 1'b1;
        test_reset_values();
        test_send_order();
        test_receive_order();
        test_receive_backpressure();
        test_send_backpressure();
        test_bus_direction();
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog, 20 clock periods per byte of all tests
    initial begin
        #(TOTAL_BYTES * 20 * CLK_PERIOD);
        $display("timeout: run did not finish within %0d clock periods", TOTAL_BYTES * 20);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_ftdi_chip_model.sv
//------------------------------------------------
// behavioral FT232H in 245 synchronous FIFO mode, offers
// queued bytes on RXF#, records writes, watches bus direction
//------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_ftdi_chip_model #(
    parameter int DRIVE_DLY = 5
) (
    input  logic                        i_clk,
    input  logic                        i_oe_n,
    input  logic                        i_rd_n,
    input  logic                        i_wr_n,
    input  logic [ftdi_pkg::DATA_W-1:0] i_data,
    input  logic                        i_data_oe,
    output logic                        o_rxf_n,
    output logic                        o_txe_n,
    output logic [ftdi_pkg::DATA_W-1:0] o_data
);

    import ftdi_pkg::*;

    logic [DATA_W-1:0] offer_q[$];
    logic [DATA_W-1:0] written_q[$];
    logic              txe_hold;
    logic              rd_fire;
    logic              wr_fire;
    int                bus_error_count;

    task automatic offer_byte(input logic [DATA_W-1:0] b);
        offer_q.push_back(b);
    endtask

    task automatic hold_txe(input logic hold);
        txe_hold = hold;
    endtask

    function automatic int written_count();
        return written_q.size();
    endfunction

    task automatic take_written(output logic [DATA_W-1:0] b);
        b = written_q.pop_front();
    endtask

    //------------------------------------------------
    // sample mid-cycle, update just after the edge
    //------------------------------------------------
    initial begin
        txe_hold        = 1'b0;
        bus_error_count = 0;
        o_rxf_n         = 1'b1;
        o_txe_n         = 1'b0;
        o_data          = '0;
        forever begin
            @(negedge i_clk);
            rd_fire = !i_rd_n && !o_rxf_n;
            wr_fire = !i_wr_n && !o_txe_n;
            if (i_data_oe && !i_oe_n) begin
                bus_error_count++;
                $display("chip model: FPGA drives the data bus while OE# is low at %0d ns",
                         $time);
            end
            if (rd_fire && i_oe_n) begin
                bus_error_count++;
                $display("chip model: read strobe without OE# low at %0d ns", $time);
            end
            if (wr_fire) begin
                written_q.push_back(i_data);
            end
            @(posedge i_clk);
            #DRIVE_DLY;
            if (rd_fire) begin
                void'(offer_q.pop_front());
            end
            // RXF# stays low while anything is left to hand over
            o_rxf_n = (offer_q.size() == 0);
            if (offer_q.size() != 0) begin
                o_data = offer_q[0];
            end
            o_txe_n = txe_hold;
        end
    end

endmodule

`default_nettype wire

// File: hw/ftdi_245fifo_top.sv
//------------------------------------------------
// 245 synchronous FIFO controller top, user byte streams
// on one side and FT232H style pins on the other
//------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ftdi_245fifo_top (
    input  logic                        i_arst_n,
    input  logic                        ftdi_clk,
    // user send stream
    input  logic                        i_tx_tvalid,
    input  logic [ftdi_pkg::DATA_W-1:0] i_tx_tdata,
    output logic                        o_tx_tready,
    // user receive stream
    output logic                        o_rx_tvalid,
    output logic [ftdi_pkg::DATA_W-1:0] o_rx_tdata,
    input  logic                        i_rx_tready,
    // chip pins, the pad tri-state sits outside
    input  logic                        i_ftdi_rxf_n,
    input  logic                        i_ftdi_txe_n,
    output logic                        o_ftdi_oe_n,
    output logic                        o_ftdi_rd_n,
    output logic                        o_ftdi_wr_n,
    input  logic [ftdi_pkg::DATA_W-1:0] i_ftdi_data,
    output logic [ftdi_pkg::DATA_W-1:0] o_ftdi_data,
    output logic                        o_ftdi_data_oe
);

    import ftdi_pkg::*;

    // send FIFO to FSM
    logic              tx_valid;
    logic [DATA_W-1:0] tx_data;
    logic              tx_ready;

    // FSM to receive FIFO
    logic              rx_valid;
    logic [DATA_W-1:0] rx_data;
    logic              rx_almost_full;

    //------------------------------------------------
    // send path
    //------------------------------------------------
    byte_fifo u_tx_fifo (
        .i_arst_n      (i_arst_n),
        .ftdi_clk      (ftdi_clk),
        .i_valid       (i_tx_tvalid),
        .i_data        (i_tx_tdata),
        .o_ready       (o_tx_tready),
        .o_almost_full (),
        .o_valid       (tx_valid),
        .o_data        (tx_data),
        .i_ready       (tx_ready)
    );

    ftdi_245fifo_fsm u_fsm (
        .i_arst_n         (i_arst_n),
        .ftdi_clk         (ftdi_clk),
        .i_tx_valid       (tx_valid),
        .i_tx_data        (tx_data),
        .o_tx_ready       (tx_ready),
        .o_rx_valid       (rx_valid),
        .o_rx_data        (rx_data),
        .i_rx_almost_full (rx_almost_full),
        .i_ftdi_rxf_n     (i_ftdi_rxf_n),
        .i_ftdi_txe_n     (i_ftdi_txe_n),
        .o_ftdi_oe_n      (o_ftdi_oe_n),
        .o_ftdi_rd_n      (o_ftdi_rd_n),
        .o_ftdi_wr_n      (o_ftdi_wr_n),
        .i_ftdi_data      (i_ftdi_data),
        .o_ftdi_data      (o_ftdi_data),
        .o_ftdi_data_oe   (o_ftdi_data_oe)
    );

    //------------------------------------------------
    // receive path
    //------------------------------------------------
    // the FSM throttles on almost-full, so ready is not needed here
    byte_fifo u_rx_fifo (
        .i_arst_n      (i_arst_n),
        .ftdi_clk      (ftdi_clk),
        .i_valid       (rx_valid),
        .i_data        (rx_data),
        .o_ready       (),
        .o_almost_full (rx_almost_full),
        .o_valid       (o_rx_tvalid),
        .o_data        (o_rx_tdata),
        .i_ready       (i_rx_tready)
    );

endmodule

`default_nettype wire

// File: ftdi_fsm/ftdi_245fifo_fsm.sv
//------------------------------------------------
// owns the 245 FIFO pins: picks read or write, keeps a
// turnaround cycle and registers every chip output
//------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ftdi_245fifo_fsm (
    input  logic                        i_arst_n,
    input  logic                        ftdi_clk,
    // from the send FIFO
    input  logic                        i_tx_valid,
    input  logic [ftdi_pkg::DATA_W-1:0] i_tx_data,
    output logic                        o_tx_ready,
    // to the receive FIFO
    output logic                        o_rx_valid,
    output logic [ftdi_pkg::DATA_W-1:0] o_rx_data,
    input  logic                        i_rx_almost_full,
    // chip side
    input  logic                        i_ftdi_rxf_n,
    input  logic                        i_ftdi_txe_n,
    output logic                        o_ftdi_oe_n,
    output logic                        o_ftdi_rd_n,
    output logic                        o_ftdi_wr_n,
    input  logic [ftdi_pkg::DATA_W-1:0] i_ftdi_data,
    output logic [ftdi_pkg::DATA_W-1:0] o_ftdi_data,
    output logic                        o_ftdi_data_oe
);

    import ftdi_pkg::*;

    logic [ST_W-1:0] state;

    // one-byte holding register, it is what the bus carries
    logic [DATA_W-1:0] tx_buf;
    logic              tx_buf_valid;
    logic              tx_buf_valid_next;

    logic tx_fire;
    logic tx_load;
    logic rx_fire;

    logic rx_go;
    logic tx_start;
    logic tx_go;

    //------------------------------------------------
    // handshake terms
    //------------------------------------------------
    // chip takes a byte when WR# and TXE# are both low
    assign tx_fire = !o_ftdi_wr_n && !i_ftdi_txe_n;

    // chip hands over a byte when RD# and RXF# are both low
    assign rx_fire = !o_ftdi_rd_n && !i_ftdi_rxf_n;

    // refill only when empty or the current byte just went out
    assign o_tx_ready = !tx_buf_valid || tx_fire;
    assign tx_load    = o_tx_ready && i_tx_valid;

    always_comb begin
        tx_buf_valid_next = tx_buf_valid;
        if (tx_load) begin
            tx_buf_valid_next = 1'b1;
        end else if (tx_fire) begin
            tx_buf_valid_next = 1'b0;
        end
    end

    // almost-full leaves room for the byte read on the edge RD# rises
    assign rx_go    = !i_ftdi_rxf_n && !i_rx_almost_full;
    assign tx_start = tx_buf_valid && !i_ftdi_txe_n;
    assign tx_go    = tx_buf_valid_next && !i_ftdi_txe_n;

    //------------------------------------------------
    // bus state machine
    //------------------------------------------------
    always_ff @(posedge ftdi_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state          <= ST_IDLE;
            o_ftdi_oe_n    <= 1'b1;
            o_ftdi_rd_n    <= 1'b1;
            o_ftdi_wr_n    <= 1'b1;
            o_ftdi_data_oe <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // reads win when both sides are ready
                    if (rx_go) begin
                        state       <= ST_RX_OE;
                        o_ftdi_oe_n <= 1'b0;
                    end else if (tx_start) begin
                        state          <= ST_TX_WRITE;
                        o_ftdi_wr_n    <= 1'b0;
                        o_ftdi_data_oe <= 1'b1;
                    end
                end
                ST_RX_OE: begin
                    // OE# has been low a full cycle before RD# falls
                    if (rx_go) begin
                        state       <= ST_RX_READ;
                        o_ftdi_rd_n <= 1'b0;
                    end else begin
                        state       <= ST_TURN;
                        o_ftdi_oe_n <= 1'b1;
                    end
                end
                ST_RX_READ: begin
                    if (!rx_go) begin
                        state       <= ST_TURN;
                        o_ftdi_oe_n <= 1'b1;
                        o_ftdi_rd_n <= 1'b1;
                    end
                end
                ST_TX_WRITE: begin
                    // a byte refused under TXE# high stays in tx_buf
                    if (!tx_go) begin
                        state          <= ST_TURN;
                        o_ftdi_wr_n    <= 1'b1;
                        o_ftdi_data_oe <= 1'b0;
                    end
                end
                ST_TURN: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state          <= ST_IDLE;
                    o_ftdi_oe_n    <= 1'b1;
                    o_ftdi_rd_n    <= 1'b1;
                    o_ftdi_wr_n    <= 1'b1;
                    o_ftdi_data_oe <= 1'b0;
                end
            endcase
        end
    end

    //------------------------------------------------
    // send holding register
    //------------------------------------------------
    always_ff @(posedge ftdi_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            tx_buf_valid <= 1'b0;
        end else begin
            tx_buf_valid <= tx_buf_valid_next;
        end
    end

    always_ff @(posedge ftdi_clk) begin
        if (tx_load) begin
            tx_buf <= i_tx_data;
        end
    end

    assign o_ftdi_data = tx_buf;

    //------------------------------------------------
    // receive strobe
    //------------------------------------------------
    // the pin byte is written into the FIFO on the edge it is read
    assign o_rx_valid = rx_fire;
    assign o_rx_data  = i_ftdi_data;

endmodule

`default_nettype wire

// File: hw/byte_fifo.sv
//------------------------------------------------
// show-ahead synchronous byte FIFO, valid/ready on both
// sides plus an almost-full flag for early throttling
//------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
    parameter int AW = ftdi_pkg::FIFO_AW
) (
    input  logic                        i_arst_n,
    input  logic                        ftdi_clk,
    // write side
    input  logic                        i_valid,
    input  logic [ftdi_pkg::DATA_W-1:0] i_data,
    output logic                        o_ready,
    output logic                        o_almost_full,
    // read side
    output logic                        o_valid,
    output logic [ftdi_pkg::DATA_W-1:0] o_data,
    input  logic                        i_ready
);

    import ftdi_pkg::*;

    logic [DATA_W-1:0] mem [2**AW];

    // one extra bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] fill;

    logic empty;
    logic full;
    logic push;
    logic pop;

    assign fill  = wr_ptr - rd_ptr;
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign push = i_valid && !full;
    assign pop  = o_valid && i_ready;

    assign o_ready = !full;

    // raised once fewer than the margin entries are free
    assign o_almost_full = (int'(fill) + RX_AFULL_MARGIN) > (2 ** AW);

    // head byte shows as soon as it is stored
    assign o_valid = !empty;
    assign o_data  = mem[rd_ptr[AW-1:0]];

    //------------------------------------------------
    // pointers
    //------------------------------------------------
    always_ff @(posedge ftdi_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge ftdi_clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= i_data;
        end
    end

endmodule

`default_nettype wire

// File: common/ftdi_pkg.sv
//------------------------------------------------
// shared widths, FIFO sizing and bus FSM state codes
// for the 245 synchronous FIFO controller
//------------------------------------------------

`default_nettype none

package ftdi_pkg;

    //------------------------------------------------
    // data path
    //------------------------------------------------
    // FT232H style bus, user streams match it
    localparam int DATA_W = 8;

    // each FIFO holds 2**FIFO_AW bytes
    localparam int FIFO_AW = 4;
    localparam int FIFO_DEPTH = 1 << FIFO_AW;

    // free entries kept for the bytes still in flight after RD# rises
    localparam int RX_AFULL_MARGIN = 2;

    //------------------------------------------------
    // bus FSM
    //------------------------------------------------
    localparam int ST_W = 3;

    localparam logic [ST_W-1:0] ST_IDLE     = 3'd0;
    localparam logic [ST_W-1:0] ST_RX_OE    = 3'd1;
    localparam logic [ST_W-1:0] ST_RX_READ  = 3'd2;
    localparam logic [ST_W-1:0] ST_TX_WRITE = 3'd3;
    localparam logic [ST_W-1:0] ST_TURN     = 3'd4;

endpackage

`default_nettype wire
